// File: vlog.f
+incdir+hdl
hdl/dcc_pkg.sv
hdl/host_byte_walker.sv
hdl/dcc_register_file.sv
hdl/payload_queue.sv
hdl/data_channel_controller.sv
verif/data_channel_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module data_channel_controller_tb -o dcc_sim \
    && ./obj_dir/dcc_sim | tee /dev/stderr | grep -qx "Everything OK" \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }

// File: verif/data_channel_controller_tb.sv
`timescale 1ns/1ps
`include "dcc_settings.svh"

module data_channel_controller_tb;
    import dcc_pkg::*;

    localparam int DEPTH      = `DCC_QUEUE_DEPTH;
    localparam int WAIT_LIMIT = 100;
    localparam int POLL_LIMIT = 8;

    logic         clk            = 1'b0;
    logic         reset          = 1'b1;
    logic         host_cmd_valid = 1'b0;
    host_cmd_t    host_cmd       = '0;
    logic         host_cmd_ready;
    logic         host_rsp_valid;
    host_rsp_t    host_rsp;
    logic         req_valid;
    dcc_payload_t req;
    logic         req_ready      = 1'b1;
    logic         resp_valid     = 1'b0;
    dcc_payload_t resp           = '0;
    logic         resp_ready;

    logic [31:0]  lcg_state    = 32'hfd54;
    int           errors       = 0;
    int           stall_errors = 0;
    int           tests_run    = 0;
    int           tests_failed = 0;
    int           errors_at_start;
    dcc_payload_t sent_q[$];
    dcc_payload_t expect_q[$];

    data_channel_controller DUT (.*);

    always #5 clk = ~clk;

    // Link side monitor records each request that leaves the DUT
    always @(posedge clk) begin
        if (!reset && req_valid && req_ready) begin
            sent_q.push_back(req);
        end
    end

    // A stalled request must hold still until the link takes it
    req_hold_check: assert property (@(posedge clk) disable iff (reset)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else begin
            $display("Request payload changed or dropped while req_ready was low");
            stall_errors++;
        end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic dcc_payload_t random_payload();
        dcc_payload_t p;
        logic [31:0]  r;
        r           = next_rand();
        p.command   = dcc_cmd_e'({6'd0, r[1:0]});
        p.tag       = r[15:8];
        p.byte_en   = r[19:16];
        p.op_status = r[31:24];
        p.address   = next_rand();
        p.data      = next_rand();
        return p;
    endfunction

    function automatic int error_total();
        return errors + stall_errors;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_payload(input string name, input dcc_payload_t got,
                                 input dcc_payload_t expected);
        assert (got === expected) else begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    task automatic begin_test();
        errors_at_start = error_total();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_total() == errors_at_start) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     error_total() - errors_at_start);
        end
    endtask

    // --------------------
    // Host bus
    // --------------------
    task automatic bus_access(input logic wr, input logic [3:0] word, input logic [3:0] be,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        rdata = '0;
        @(negedge clk);
        host_cmd_valid      = 1'b1;
        host_cmd.write      = wr;
        host_cmd.address    = {word, 2'b00};
        host_cmd.byteenable = be;
        host_cmd.writedata  = wdata;
        cycles = 0;
        while (!host_cmd_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!host_cmd_ready) begin
            $display("Host command to word %0d was not accepted in time", word);
            errors++;
            host_cmd_valid = 1'b0;
            return;
        end
        // Ready seen here means the next rising edge takes the command
        @(negedge clk);
        host_cmd_valid = 1'b0;
        cycles = 0;
        while (!host_rsp_valid && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!host_rsp_valid) begin
            $display("No host response for word %0d", word);
            errors++;
            return;
        end
        check_word("host_rsp.is_read", 32'(host_rsp.is_read), 32'(!wr));
        rdata = host_rsp.readdata;
    endtask

    task automatic write_word(input logic [3:0] word, input logic [3:0] be,
                              input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(1'b1, word, be, wdata, unused);
    endtask

    task automatic read_word(input logic [3:0] word, input logic [3:0] be,
                             output logic [31:0] rdata);
        bus_access(1'b0, word, be, 32'd0, rdata);
    endtask

    task automatic write_request(input dcc_payload_t p);
        write_word(`DCC_WORD_REQ_HDR, 4'hf, {8'h00, 4'h0, p.byte_en, p.tag, p.command});
        write_word(`DCC_WORD_REQ_ADDR, 4'hf, p.address);
        write_word(`DCC_WORD_REQ_DATA, 4'hf, p.data);
    endtask

    // Polls the status word until request_write drops
    task automatic wait_request_clear(output logic cleared);
        logic [31:0] status;
        int          polls;
        cleared = 1'b0;
        polls   = 0;
        while (!cleared && polls < POLL_LIMIT) begin
            read_word(`DCC_WORD_STATUS, 4'hf, status);
            cleared = !status[0];
            polls++;
        end
    endtask

    // --------------------
    // Link model
    // --------------------
    task automatic wait_sent(input int n);
        int cycles;
        cycles = 0;
        while (sent_q.size() < n && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (sent_q.size() >= n) else begin
            $display("Only %0d of %0d requests left the DUT", sent_q.size(), n);
            errors++;
        end
    endtask

    task automatic inject_response(input dcc_payload_t p);
        int cycles;
        @(negedge clk);
        resp_valid = 1'b1;
        resp       = p;
        cycles     = 0;
        while (!resp_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (resp_ready) else begin
            $display("Link response was not accepted in time");
            errors++;
        end
        @(negedge clk);
        resp_valid = 1'b0;
    endtask

    initial begin
        logic [31:0]  rdata;
        logic [31:0]  wdata;
        logic [31:0]  r;
        logic [31:0]  addr_model;
        logic         cleared;
        int           base;
        dcc_payload_t p;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test();
        check_word("req_valid", 32'(req_valid), 32'd0);
        check_word("resp_ready", 32'(resp_ready), 32'd1);
        check_word("host_cmd_ready", 32'(host_cmd_ready), 32'd1);
        read_word(`DCC_WORD_STATUS, 4'hf, rdata);
        check_word("status", rdata, 32'h4);
        read_word(`DCC_WORD_REQ_HDR, 4'hf, rdata);
        check_word("request header", rdata, 32'h0);
        end_test("reset state");

        begin_test();
        addr_model = 32'd0;
        repeat (8) begin
            wdata = next_rand();
            r     = next_rand();
            write_word(`DCC_WORD_REQ_ADDR, r[3:0], wdata);
            for (int i = 0; i < 4; i++) begin
                if (r[i]) addr_model[8*i +: 8] = wdata[8*i +: 8];
            end
            read_word(`DCC_WORD_REQ_ADDR, 4'hf, rdata);
            check_word("request address", rdata, addr_model);
        end
        read_word(`DCC_WORD_REQ_ADDR, 4'b0101, rdata);
        check_word("request address lanes 0 and 2", rdata, addr_model & 32'h00ff00ff);
        write_word(4'd9, 4'hf, next_rand());
        read_word(4'd9, 4'hf, rdata);
        check_word("unmapped word 9", rdata, 32'h0);
        end_test("byte enables");

        begin_test();
        base = sent_q.size();
        p = random_payload();
        p.op_status = 8'd0;
        write_request(p);
        write_word(`DCC_WORD_STATUS, 4'b0001, 32'h1);
        wait_sent(base + 1);
        if (sent_q.size() > base) check_payload("req", sent_q[base], p);
        read_word(`DCC_WORD_STATUS, 4'hf, rdata);
        check_word("status", rdata, 32'h4);
        end_test("request send");

        // --------------------
        // Link stalled with one request more than the queue holds
        // --------------------
        begin_test();
        base = sent_q.size();
        expect_q.delete();
        @(negedge clk);
        req_ready = 1'b0;
        for (int k = 0; k <= DEPTH; k++) begin
            p = random_payload();
            p.op_status = 8'd0;
            expect_q.push_back(p);
            write_request(p);
            write_word(`DCC_WORD_STATUS, 4'b0001, 32'h1);
            wait_request_clear(cleared);
            if (k < DEPTH) begin
                assert (cleared) else begin
                    $display("Request %0d was not taken by the request queue", k);
                    errors++;
                end
            end else begin
                assert (!cleared) else begin
                    $display("Request %0d was taken while the request queue was full", k);
                    errors++;
                end
            end
            if (k == DEPTH - 1) begin
                read_word(`DCC_WORD_STATUS, 4'hf, rdata);
                check_word("status with full queue", rdata, 32'h0);
            end
        end
        check_payload("req while stalled", req, expect_q[0]);
        @(negedge clk);
        req_ready = 1'b1;
        wait_sent(base + DEPTH + 1);
        for (int k = 0; k <= DEPTH; k++) begin
            if (sent_q.size() > base + k) check_payload("req", sent_q[base + k], expect_q[k]);
        end
        end_test("request back-pressure");

        begin_test();
        expect_q.delete();
        for (int k = 0; k < 3; k++) begin
            p = random_payload();
            expect_q.push_back(p);
            inject_response(p);
        end
        read_word(`DCC_WORD_STATUS, 4'hf, rdata);
        check_word("status with responses", rdata, 32'hc);
        for (int k = 0; k < 3; k++) begin
            p = expect_q[k];
            write_word(`DCC_WORD_STATUS, 4'b0001, 32'h2);
            read_word(`DCC_WORD_RESP_HDR, 4'hf, rdata);
            check_word("response header", rdata,
                       {p.op_status, 4'h0, p.byte_en, p.tag, p.command});
            read_word(`DCC_WORD_RESP_ADDR, 4'hf, rdata);
            check_word("response address", rdata, p.address);
            read_word(`DCC_WORD_RESP_DATA, 4'hf, rdata);
            check_word("response data", rdata, p.data);
        end
        read_word(`DCC_WORD_STATUS, 4'hf, rdata);
        check_word("status after responses", rdata, 32'h4);
        end_test("response receive");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_total());
        if (error_total() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: hdl/data_channel_controller.sv
`timescale 1ns/1ps

module data_channel_controller (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  host_cmd_valid,
    input  dcc_pkg::host_cmd_t    host_cmd,
    output logic                  host_cmd_ready,
    output logic                  host_rsp_valid,
    output dcc_pkg::host_rsp_t    host_rsp,
    output logic                  req_valid,
    output dcc_pkg::dcc_payload_t req,
    input  logic                  req_ready,
    input  logic                  resp_valid,
    input  dcc_pkg::dcc_payload_t resp,
    output logic                  resp_ready
);
    import dcc_pkg::*;

    logic         byte_valid;
    byte_access_t byte_access;
    logic [7:0]   byte_rdata;
    logic         req_push_valid;
    logic         req_push_ready;
    dcc_payload_t req_push;
    logic         req_full;
    logic         resp_pop_valid;
    logic         resp_pop_ready;
    dcc_payload_t resp_head;
    logic         resp_empty;

    // --------------------
    // Host side
    // --------------------
    host_byte_walker u_walker (
        .clk, .reset, .host_cmd_valid, .host_cmd, .host_cmd_ready,
        .host_rsp_valid, .host_rsp, .byte_valid, .byte_access, .byte_rdata
    );

    dcc_register_file u_regs (
        .clk, .reset, .byte_valid, .byte_access, .byte_rdata,
        .req_push_valid, .req_push, .req_push_ready, .req_full,
        .resp_pop_valid, .resp_head, .resp_pop_ready, .resp_empty
    );

    // --------------------
    // Link side queues
    // --------------------
    payload_queue u_req_queue (
        .clk, .reset,
        .push_valid (req_push_valid), .push_data (req_push), .push_ready (req_push_ready),
        .pop_valid  (req_valid),      .pop_data  (req),      .pop_ready  (req_ready),
        .full       (req_full),       .empty     ()
    );

    payload_queue u_resp_queue (
        .clk, .reset,
        .push_valid (resp_valid),     .push_data (resp),      .push_ready (resp_ready),
        .pop_valid  (resp_pop_valid), .pop_data  (resp_head), .pop_ready  (resp_pop_ready),
        .full       (),               .empty     (resp_empty)
    );

endmodule

// File: hdl/payload_queue.sv
`timescale 1ns/1ps
`include "dcc_settings.svh"

module payload_queue #(
    parameter int DEPTH = `DCC_QUEUE_DEPTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push_valid,
    input  dcc_pkg::dcc_payload_t push_data,
    output logic                  push_ready,
    output logic                  pop_valid,
    output dcc_pkg::dcc_payload_t pop_data,
    input  logic                  pop_ready,
    output logic                  full,
    output logic                  empty
);
    import dcc_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dcc_payload_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_fire;
    logic             pop_fire;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign full       = (count == CNT_W'(DEPTH));
    assign empty      = (count == '0);
    assign push_ready = !full;
    assign pop_valid  = !empty;
    assign pop_data   = mem[rd_ptr];
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) wr_ptr <= next_ptr(wr_ptr);
            if (pop_fire) rd_ptr <= next_ptr(rd_ptr);
            case ({push_fire, pop_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) mem[wr_ptr] <= push_data;
    end

endmodule

// File: hdl/dcc_register_file.sv
`timescale 1ns/1ps
`include "dcc_settings.svh"

module dcc_register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  byte_valid,
    input  dcc_pkg::byte_access_t byte_access,
    output logic [7:0]            byte_rdata,
    output logic                  req_push_valid,
    output dcc_pkg::dcc_payload_t req_push,
    input  logic                  req_push_ready,
    input  logic                  req_full,
    input  logic                  resp_pop_valid,
    input  dcc_pkg::dcc_payload_t resp_head,
    output logic                  resp_pop_ready,
    input  logic                  resp_empty
);
    import dcc_pkg::*;

    localparam int WORD_W = `DCC_ADDR_WIDTH - 2;

    logic [WORD_W-1:0] word;
    logic [1:0]        lane;
    logic              wr_en;
    logic [7:0]        req_cmd;
    logic [7:0]        req_tag;
    logic [3:0]        req_ben;
    logic [3:0][7:0]   req_addr;
    logic [3:0][7:0]   req_data;
    logic              request_write;
    logic              response_read;
    logic              set_request;
    logic              set_response;
    logic              load_push;
    logic              push_fire;
    logic              pop_fire;
    logic [7:0]        status_byte;
    dcc_payload_t      resp_q;

    assign word  = byte_access.addr[`DCC_ADDR_WIDTH-1:2];
    assign lane  = byte_access.addr[1:0];
    assign wr_en = byte_valid && byte_access.wr;

    // Command bits are write-one-to-set
    assign set_request  = wr_en && (word == `DCC_WORD_STATUS) && (lane == 2'd0)
                          && byte_access.wdata[0];
    assign set_response = wr_en && (word == `DCC_WORD_STATUS) && (lane == 2'd0)
                          && byte_access.wdata[1];

    assign load_push      = request_write && !req_push_valid;
    assign push_fire      = req_push_valid && req_push_ready;
    assign resp_pop_ready = response_read;
    assign pop_fire       = resp_pop_valid && response_read;

    assign status_byte = {4'd0, !resp_empty, !req_full, response_read, request_write};

    // --------------------
    // Host writable registers
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_cmd  <= 8'd0;
            req_tag  <= 8'd0;
            req_ben  <= 4'd0;
            req_addr <= '0;
            req_data <= '0;
        end else if (wr_en) begin
            case (word)
                `DCC_WORD_REQ_HDR: begin
                    case (lane)
                        2'd0: req_cmd <= byte_access.wdata;
                        2'd1: req_tag <= byte_access.wdata;
                        2'd2: req_ben <= byte_access.wdata[3:0];
                        default: ;
                    endcase
                end
                `DCC_WORD_REQ_ADDR: req_addr[lane] <= byte_access.wdata;
                `DCC_WORD_REQ_DATA: req_data[lane] <= byte_access.wdata;
                default: ;
            endcase
        end
    end

    // --------------------
    // Queue handshakes
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            request_write  <= 1'b0;
            response_read  <= 1'b0;
            req_push_valid <= 1'b0;
        end else begin
            if (load_push) begin
                req_push_valid <= 1'b1;
            end else if (push_fire) begin
                req_push_valid <= 1'b0;
            end

            // A new set from the host wins over the hardware clear
            if (set_request) begin
                request_write <= 1'b1;
            end else if (push_fire) begin
                request_write <= 1'b0;
            end

            if (set_response) begin
                response_read <= 1'b1;
            end else if (pop_fire) begin
                response_read <= 1'b0;
            end
        end
    end

    // Request snapshot held until the queue takes it, response head load
    always_ff @(posedge clk) begin
        if (load_push) begin
            req_push.command   <= dcc_cmd_e'(req_cmd);
            req_push.tag       <= req_tag;
            req_push.byte_en   <= req_ben;
            req_push.op_status <= 8'd0;
            req_push.address   <= req_addr;
            req_push.data      <= req_data;
        end
        if (pop_fire) begin
            resp_q <= resp_head;
        end
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        byte_rdata = 8'd0;
        case (word)
            `DCC_WORD_STATUS: begin
                if (lane == 2'd0) begin
                    byte_rdata = status_byte;
                end
            end
            `DCC_WORD_REQ_HDR: begin
                case (lane)
                    2'd0: byte_rdata = req_cmd;
                    2'd1: byte_rdata = req_tag;
                    2'd2: byte_rdata = {4'd0, req_ben};
                    default: byte_rdata = 8'd0;
                endcase
            end
            `DCC_WORD_REQ_ADDR: byte_rdata = req_addr[lane];
            `DCC_WORD_REQ_DATA: byte_rdata = req_data[lane];
            `DCC_WORD_RESP_HDR: begin
                case (lane)
                    2'd0: byte_rdata = resp_q.command;
                    2'd1: byte_rdata = resp_q.tag;
                    2'd2: byte_rdata = {4'd0, resp_q.byte_en};
                    default: byte_rdata = resp_q.op_status;
                endcase
            end
            `DCC_WORD_RESP_ADDR: byte_rdata = resp_q.address[lane];
            `DCC_WORD_RESP_DATA: byte_rdata = resp_q.data[lane];
            default: byte_rdata = 8'd0;
        endcase
    end

endmodule

// File: hdl/host_byte_walker.sv
`timescale 1ns/1ps
`include "dcc_settings.svh"

module host_byte_walker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  host_cmd_valid,
    input  dcc_pkg::host_cmd_t    host_cmd,
    output logic                  host_cmd_ready,
    output logic                  host_rsp_valid,
    output dcc_pkg::host_rsp_t    host_rsp,
    output logic                  byte_valid,
    output dcc_pkg::byte_access_t byte_access,
    input  logic [7:0]            byte_rdata
);
    import dcc_pkg::*;

    walker_state_e   state;
    host_cmd_t       cmd_q;
    logic [3:0][7:0] data_q;
    logic [3:0]      lanes_left;
    logic [3:0]      lanes_next;
    logic [1:0]      lane;
    logic            settle;
    logic            accept;

    // Extra idle cycle after the response keeps ready low
    assign host_cmd_ready = (state == WALKER_IDLE) && !settle;
    assign accept         = host_cmd_valid && host_cmd_ready;

    // --------------------
    // Lane selection
    // --------------------

    // Lowest enabled lane still to be visited
    always_comb begin
        lane = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (lanes_left[i]) begin
                lane = 2'(i);
            end
        end
    end

    assign lanes_next = lanes_left & ~(4'b0001 << lane);

    // --------------------
    // Byte access and response
    // --------------------
    assign byte_valid        = (state == WALKER_WALK);
    assign byte_access.wr    = cmd_q.write;
    assign byte_access.addr  = {cmd_q.address[`DCC_ADDR_WIDTH-1:2], lane};
    assign byte_access.wdata = data_q[lane];

    assign host_rsp_valid    = (state == WALKER_RESPOND);
    assign host_rsp.is_read  = !cmd_q.write;
    assign host_rsp.readdata = cmd_q.write ? '0 : data_q;

    // --------------------
    // Control FSM
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= WALKER_IDLE;
            lanes_left <= 4'd0;
            settle     <= 1'b0;
        end else begin
            settle <= 1'b0;
            case (state)
                WALKER_IDLE: begin
                    if (accept) begin
                        lanes_left <= host_cmd.byteenable;
                        // No lane enabled goes straight to the response
                        if (host_cmd.byteenable == 4'd0) begin
                            state <= WALKER_RESPOND;
                        end else begin
                            state <= WALKER_WALK;
                        end
                    end
                end
                WALKER_WALK: begin
                    lanes_left <= lanes_next;
                    if (lanes_next == 4'd0) begin
                        state <= WALKER_RESPOND;
                    end
                end
                WALKER_RESPOND: begin
                    settle <= 1'b1;
                    state  <= WALKER_IDLE;
                end
                default: begin
                    state <= WALKER_IDLE;
                end
            endcase
        end
    end

    // Command and data lanes, disabled read lanes stay zero
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q  <= host_cmd;
            data_q <= host_cmd.write ? host_cmd.writedata : '0;
        end else if ((state == WALKER_WALK) && !cmd_q.write) begin
            data_q[lane] <= byte_rdata;
        end
    end

endmodule

// File: hdl/dcc_pkg.sv
`include "dcc_settings.svh"

package dcc_pkg;

    // Link command codes, carried through untouched
    typedef enum logic [7:0] {
        CMD_MEM_READ  = 8'h00,
        CMD_MEM_WRITE = 8'h01,
        CMD_IO_READ   = 8'h02,
        CMD_IO_WRITE  = 8'h03
    } dcc_cmd_e;

    // Host bus walker states
    typedef enum logic [1:0] {
        WALKER_IDLE,
        WALKER_WALK,
        WALKER_RESPOND
    } walker_state_e;

    // One link transaction, request or response
    typedef struct packed {
        dcc_cmd_e        command;
        logic [7:0]      tag;
        logic [3:0]      byte_en;
        logic [7:0]      op_status;
        logic [3:0][7:0] address;
        logic [3:0][7:0] data;
    } dcc_payload_t;

    // Word command from the host
    typedef struct packed {
        logic                       write;
        logic [`DCC_ADDR_WIDTH-1:0] address;
        logic [3:0]                 byteenable;
        logic [3:0][7:0]            writedata;
    } host_cmd_t;

    typedef struct packed {
        logic            is_read;
        logic [3:0][7:0] readdata;
    } host_rsp_t;

    // Single byte access into the register file
    typedef struct packed {
        logic                       wr;
        logic [`DCC_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 wdata;
    } byte_access_t;

endpackage

// File: hdl/dcc_settings.svh
`ifndef DCC_SETTINGS_SVH
`define DCC_SETTINGS_SVH

// Payload entries held by each link queue
`define DCC_QUEUE_DEPTH 4

// Byte address width of the register space (64 bytes, 16 words)
`define DCC_ADDR_WIDTH 6

// --------------------
// Word offsets of the register map
// --------------------
`define DCC_WORD_STATUS    4'd0
`define DCC_WORD_REQ_HDR   4'd1
`define DCC_WORD_REQ_ADDR  4'd2
`define DCC_WORD_REQ_DATA  4'd3
`define DCC_WORD_RESP_HDR  4'd4
`define DCC_WORD_RESP_ADDR 4'd5
`define DCC_WORD_RESP_DATA 4'd6

`endif
